/* Bender.yml */
package:
  name: mips_soc

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_cpu.sv
  - rtl/boot_loader.sv
  - rtl/bus_arbiter.sv
  - rtl/avalon_ram.sv
  - rtl/soc_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_soc.sv

/* rtl/avalon_ram.sv */
`timescale 1ns/1ps

module avalon_ram (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mips_pkg::avalon_req_t bus_req,
    output mips_pkg::avalon_rsp_t bus_rsp
);
    import mips_pkg::*;

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;
    logic [31:0]       rdata_q;
    logic              rd_phase_q;  // second cycle of a read.

    assign idx = bus_req.address[RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (bus_req.write) mem[idx] <= bus_req.writedata;  // write lands at once.
        rdata_q <= mem[idx];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_phase_q <= 1'b0;
        end else begin
            rd_phase_q <= bus_req.read && !rd_phase_q;
        end
    end

    // first read cycle stalls, data comes from the registered word.
    assign bus_rsp.waitrequest = bus_req.read && !rd_phase_q;
    assign bus_rsp.readdata    = rdata_q;

endmodule

/* rtl/boot_loader.sv */
`timescale 1ns/1ps

module boot_loader (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load_valid,
    input  mips_pkg::load_word_t  load_word,
    input  mips_pkg::avalon_rsp_t bus_rsp,
    output mips_pkg::avalon_req_t bus_req
);
    import mips_pkg::*;

    load_word_t           fifo_q [LOADER_DEPTH];
    logic [LOADER_AW-1:0] wr_ptr_q, rd_ptr_q;
    logic [LOADER_AW:0]   count_q;
    load_word_t           head;
    logic                 pop;

    assign head = fifo_q[rd_ptr_q];
    assign pop  = bus_req.write && !bus_rsp.waitrequest;  // word accepted by RAM.

    always_comb begin
        bus_req           = '0;
        bus_req.write     = (count_q != '0);
        bus_req.address   = {22'd0, head.addr, 2'b00};  // word to byte address.
        bus_req.writedata = head.data;
    end

    always_ff @(posedge clk) begin
        if (load_valid) fifo_q[wr_ptr_q] <= load_word;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (load_valid) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({load_valid, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // both or neither.
            endcase
        end
    end

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mips_pkg::avalon_req_t ldr_req,
    input  mips_pkg::avalon_req_t cpu_req,
    output mips_pkg::avalon_rsp_t ldr_rsp,
    output mips_pkg::avalon_rsp_t cpu_rsp,
    output mips_pkg::avalon_req_t ram_req,
    input  mips_pkg::avalon_rsp_t ram_rsp
);

    logic busy_q;     // a granted transfer is still waiting.
    logic own_ldr_q;
    logic ldr_wants;
    logic sel_ldr;
    logic xfer;

    assign ldr_wants = ldr_req.read | ldr_req.write;

    // new grants only when idle, loader first.
    assign sel_ldr = busy_q ? own_ldr_q : ldr_wants;
    assign ram_req = sel_ldr ? ldr_req : cpu_req;
    assign xfer    = ram_req.read | ram_req.write;

    always_comb begin
        ldr_rsp.readdata    = ram_rsp.readdata;
        cpu_rsp.readdata    = ram_rsp.readdata;
        ldr_rsp.waitrequest = sel_ldr ? ram_rsp.waitrequest : 1'b1;
        cpu_rsp.waitrequest = sel_ldr ? 1'b1 : ram_rsp.waitrequest;
    end

    // hold the owner until its transfer sees waitrequest low.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q    <= 1'b0;
            own_ldr_q <= 1'b0;
        end else begin
            busy_q    <= xfer && ram_rsp.waitrequest;
            own_ldr_q <= sel_ldr;
        end
    end

endmodule

/* rtl/mips_cpu.sv */
`timescale 1ns/1ps

module mips_cpu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  mips_pkg::avalon_rsp_t bus_rsp,
    output mips_pkg::avalon_req_t bus_req,
    output logic                  active,
    output logic [31:0]           register_v0
);
    import mips_pkg::*;

    cpu_state_e  state_q, state_d;
    logic [31:0] pc_q, pc_d;
    logic        active_q, active_d;

    logic [31:0] regs [32];
    logic [31:0] ir_q, a_q, b_q, alu_q, mdr_q;

    opcode_e     op;
    funct_e      fn;
    logic [4:0]  rs, rt, rd;
    logic [31:0] imm_sext, alu_res;
    logic [31:0] pc_plus4, br_target;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    assign op       = opcode_e'(ir_q[31:26]);
    assign fn       = funct_e'(ir_q[5:0]);
    assign rs       = ir_q[25:21];
    assign rt       = ir_q[20:16];
    assign rd       = ir_q[15:11];
    assign imm_sext = {{16{ir_q[15]}}, ir_q[15:0]};
    assign pc_plus4 = pc_q + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};  // no delay slot.

    // only addu adds two registers.
    assign alu_res = (op == OP_SPECIAL) ? a_q + b_q : a_q + imm_sext;

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        active_d = active_q;
        case (state_q)
            S_IDLE, S_HALTED: begin
                if (start) begin
                    state_d  = S_FETCH;
                    pc_d     = RESET_PC;
                    active_d = 1'b1;
                end
            end
            S_FETCH: begin
                if (!bus_rsp.waitrequest) state_d = S_DECODE;
            end
            S_DECODE: state_d = S_EXECUTE;
            S_EXECUTE: begin
                state_d = S_FETCH;  // most ops go straight back.
                pc_d    = pc_plus4;  // next pc for every op.
                case (op)
                    OP_SPECIAL: begin
                        case (fn)
                            FN_ADDU: state_d = S_WRITEBACK;
                            FN_JR: begin
                                if (a_q == 32'd0) begin
                                    state_d  = S_HALTED;  // end of program.
                                    active_d = 1'b0;
                                end else begin
                                    pc_d = a_q;
                                end
                            end
                            default: ;
                        endcase
                    end
                    OP_ADDIU: state_d = S_WRITEBACK;
                    OP_LW, OP_SW: state_d = S_MEMORY;
                    OP_BEQ: pc_d = (a_q == b_q) ? br_target : pc_plus4;
                    OP_BGTZ: pc_d = ($signed(a_q) > 32'sd0) ? br_target : pc_plus4;
                    default: ;
                endcase
            end
            S_MEMORY: begin
                if (!bus_rsp.waitrequest) begin
                    if (op == OP_SW) begin
                        state_d = S_FETCH;
                    end else begin
                        state_d = S_WRITEBACK;
                    end
                end
            end
            S_WRITEBACK: begin
                state_d = S_FETCH;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= S_IDLE;
            pc_q     <= RESET_PC;
            active_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            pc_q     <= pc_d;
            active_q <= active_d;
        end
    end

    // datapath latches.
    always_ff @(posedge clk) begin
        if (state_q == S_FETCH && !bus_rsp.waitrequest) ir_q <= bus_rsp.readdata;
        if (state_q == S_DECODE) begin
            a_q <= regs[rs];
            b_q <= regs[rt];
        end
        if (state_q == S_EXECUTE) alu_q <= alu_res;
        if (state_q == S_MEMORY && !bus_rsp.waitrequest) mdr_q <= bus_rsp.readdata;
    end

    always_comb begin
        wb_en   = (state_q == S_WRITEBACK);
        wb_addr = (op == OP_SPECIAL) ? rd : rt;
        wb_data = (op == OP_LW) ? mdr_q : alu_q;
    end

    // register file is zeroed by reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != 5'd0) begin
            regs[wb_addr] <= wb_data;  // r0 stays zero.
        end
    end

    always_comb begin
        bus_req = '0;
        case (state_q)
            S_FETCH: begin
                bus_req.read    = 1'b1;
                bus_req.address = pc_q;
            end
            S_MEMORY: begin
                bus_req.address   = alu_q;
                bus_req.writedata = b_q;
                bus_req.read      = (op == OP_LW);
                bus_req.write     = (op == OP_SW);
            end
            default: ;
        endcase
    end

    assign active      = active_q;
    assign register_v0 = regs[REG_V0];

endmodule

/* rtl/mips_pkg.sv */
package mips_pkg;

    localparam int RAM_WORDS    = 256;
    localparam int RAM_AW       = $clog2(RAM_WORDS);
    localparam int LOADER_DEPTH = 4;
    localparam int LOADER_AW    = $clog2(LOADER_DEPTH);

    localparam logic [31:0] RESET_PC = 32'h4;  // first instruction word.
    localparam logic [4:0]  REG_V0   = 5'd2;

    // one master request on the memory-mapped bus.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avalon_req_t;

    typedef struct packed {
        logic [31:0] readdata;
        logic        waitrequest;
    } avalon_rsp_t;

    // one word from the load port, word addressed.
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } load_word_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21
    } funct_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALTED
    } cpu_state_e;

endpackage

/* rtl/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load_valid,
    input  mips_pkg::load_word_t load_word,
    input  logic                 start,
    output logic                 active,
    output logic [31:0]          register_v0
);
    import mips_pkg::*;

    avalon_req_t cpu_req, ldr_req, ram_req;
    avalon_rsp_t cpu_rsp, ldr_rsp, ram_rsp;

    mips_cpu u_cpu (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .bus_rsp     (cpu_rsp),
        .bus_req     (cpu_req),
        .active      (active),
        .register_v0 (register_v0)
    );

    boot_loader u_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .load_valid (load_valid),
        .load_word  (load_word),
        .bus_rsp    (ldr_rsp),
        .bus_req    (ldr_req)
    );

    bus_arbiter u_arbiter (
        .clk     (clk),
        .arst_n  (arst_n),
        .ldr_req (ldr_req),
        .cpu_req (cpu_req),
        .ldr_rsp (ldr_rsp),
        .cpu_rsp (cpu_rsp),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

    avalon_ram u_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus_req (ram_req),
        .bus_rsp (ram_rsp)
    );

endmodule

/* sources.f */
rtl/mips_pkg.sv
rtl/mips_cpu.sv
rtl/boot_loader.sv
rtl/bus_arbiter.sv
rtl/avalon_ram.sv
rtl/soc_top.sv
test/tb_clock_gen.sv
test/tb_soc.sv

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic arst_n
);
    localparam int HALF_PERIOD = 20;  // 40 ns clock.

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // power-on reset, then one more reset per request pulse.
    initial begin
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        forever begin
            @(posedge reset_req);
            arst_n = 1'b0;
            repeat (3) @(negedge clk);  // released on a falling edge.
            arst_n = 1'b1;
        end
    end

endmodule

/* test/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
    import mips_pkg::*;

    localparam int N_PROGS     = 4;
    localparam int MAX_WORDS   = 8;
    localparam int CYCLE_LIMIT = N_PROGS * 400;

    logic        clk;
    logic        arst_n;
    logic        reset_req;
    logic        load_valid;
    load_word_t  load_word;
    logic        start;
    logic        active;
    logic [31:0] register_v0;

    load_word_t  prog [N_PROGS][MAX_WORDS];  // addr 0 ends the list.
    logic [31:0] expect_v0 [N_PROGS];
    logic        reset_first [N_PROGS];
    integer      seed;
    int          cycles = 0;
    int          cur_prog = 0;

    tb_clock_gen u_clk (
        .reset_req (reset_req),
        .clk       (clk),
        .arst_n    (arst_n)
    );

    soc_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_valid  (load_valid),
        .load_word   (load_word),
        .start       (start),
        .active      (active),
        .register_v0 (register_v0)
    );

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] encode_itype(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                                 logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_rtype(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                                 funct_e fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic put_word(input int p, input int w, input logic [7:0] addr,
                            input logic [31:0] data);
        prog[p][w].addr = addr;
        prog[p][w].data = data;
    endtask

    task automatic build_table();
        logic [31:0] rand_word;
        for (int p = 0; p < N_PROGS; p++) begin
            for (int w = 0; w < MAX_WORDS; w++) begin
                prog[p][w] = '0;
            end
        end
        // reference program where bgtz on r0 falls through.
        put_word(0, 0, 8'd1, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'h0050));
        put_word(0, 1, 8'd2, encode_itype(OP_BGTZ, 5'd0, 5'd0, 16'd2));
        put_word(0, 2, 8'd3, encode_itype(OP_ADDIU, 5'd2, 5'd2, 16'h0055));
        put_word(0, 3, 8'd4, encode_rtype(5'd0, 5'd0, 5'd0, FN_JR));
        expect_v0[0]   = 32'h0000_00a5;
        reset_first[0] = 1'b1;
        // taken bgtz skips the 0x100 add.
        put_word(1, 0, 8'd1, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'h0010));
        put_word(1, 1, 8'd2, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'd5));
        put_word(1, 2, 8'd3, encode_itype(OP_BGTZ, 5'd3, 5'd0, 16'd1));
        put_word(1, 3, 8'd4, encode_itype(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        put_word(1, 4, 8'd5, encode_itype(OP_ADDIU, 5'd2, 5'd2, 16'h0020));
        put_word(1, 5, 8'd6, encode_rtype(5'd0, 5'd0, 5'd0, FN_JR));
        expect_v0[1]   = 32'h0000_0030;
        reset_first[1] = 1'b0;
        // load, increment, store, load back.
        rand_word = $random(seed);
        put_word(2, 0, 8'd64, rand_word);  // data word at byte 0x100.
        put_word(2, 1, 8'd1, encode_itype(OP_LW, 5'd0, 5'd4, 16'h0100));
        put_word(2, 2, 8'd2, encode_itype(OP_ADDIU, 5'd4, 5'd4, 16'd1));
        put_word(2, 3, 8'd3, encode_itype(OP_SW, 5'd0, 5'd4, 16'h0104));
        put_word(2, 4, 8'd4, encode_itype(OP_LW, 5'd0, 5'd5, 16'h0104));
        put_word(2, 5, 8'd5, encode_rtype(5'd5, 5'd0, 5'd2, FN_ADDU));
        put_word(2, 6, 8'd6, encode_rtype(5'd0, 5'd0, 5'd0, FN_JR));
        expect_v0[2]   = rand_word + 32'd1;
        reset_first[2] = 1'b1;
        // sum of 10 down to 1.
        put_word(3, 0, 8'd1, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'd0));
        put_word(3, 1, 8'd2, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'd10));
        put_word(3, 2, 8'd3, encode_rtype(5'd2, 5'd3, 5'd2, FN_ADDU));
        put_word(3, 3, 8'd4, encode_itype(OP_ADDIU, 5'd3, 5'd3, 16'hffff));
        put_word(3, 4, 8'd5, encode_itype(OP_BEQ, 5'd3, 5'd0, 16'd1));
        put_word(3, 5, 8'd6, encode_itype(OP_BEQ, 5'd0, 5'd0, 16'hfffc));  // back to addu.
        put_word(3, 6, 8'd7, encode_rtype(5'd0, 5'd0, 5'd0, FN_JR));
        expect_v0[3]   = 32'd55;
        reset_first[3] = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        wait (arst_n);
        @(negedge clk);
        check_flag(active, 1'b0, "active after reset");
        check_word(register_v0, 32'd0, "register_v0 after reset");
    endtask

    task automatic load_program(input int p);
        int w;
        w = 0;
        while (w < MAX_WORDS && prog[p][w].addr != 8'd0) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_word  = prog[p][w];
            @(negedge clk);
            load_valid = 1'b0;
            w++;
        end
    endtask

    task automatic run_program(input int p);
        if (reset_first[p]) apply_reset();
        load_program(p);
        repeat (8) @(negedge clk);  // let the loader FIFO drain.
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag(active, 1'b1, "active after start");
        while (active) @(negedge clk);
        check_word(register_v0, expect_v0[p], $sformatf("register_v0 of program %0d", p));
        repeat (5) begin
            @(negedge clk);
            check_flag(active, 1'b0, "active after halt");
        end
    endtask

    // run limit over the whole table.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: program %0d still running after %0d cycles", cur_prog, cycles);
            stop_on_error();
        end
    end

    initial begin
        reset_req  = 1'b0;
        load_valid = 1'b0;
        load_word  = '0;
        start      = 1'b0;
        seed       = 32'hbb591581;
        build_table();
        wait (arst_n);
        @(negedge clk);
        check_flag(active, 1'b0, "active before first start");
        for (int p = 0; p < N_PROGS; p++) begin
            cur_prog = p;
            run_program(p);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule
